//--- sync_buffer_stimulus.txt
# one frame per line, vertical blank comes before the frame
# enable lines line_length h_blank v_blank random_clk_en
1 4 16 20 50 0
1 3 24 20 44 0
1 5 8 22 60 0
1 2 30 20 70 1
1 4 12 24 48 0
0 6 16 20 50 0
1 3 20 20 60 0
1 4 16 20 50 0
1 2 10 20 45 0

//--- vlog.f
sensor_pkg.sv
sensor_fifo.sv
fval_extend_timer.sv
sync_ctrl_fsm.sv
pix_out_stage.sv
sensor_sync_buffer.sv
sync_buffer_assert.sv
sync_buffer_checker.sv
tb_sync_buffer.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_sync_buffer -Mdir obj_dir -f vlog.f
	./obj_dir/Vtb_sync_buffer > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- tb_sync_buffer.sv
module tb_sync_buffer;
	import sensor_pkg::*;

	logic                  clk_pix;
	logic                  clk_sensor_pix;
	logic                  reset;
	logic                  enable;
	logic                  clk_en;
	logic                  fval;
	logic                  lval;
	logic [DATA_WIDTH-1:0] pix_data;
	logic                  out_fval;
	logic                  out_lval;
	logic [DATA_WIDTH-1:0] out_pix_data;

	// checker results
	logic chk_idle;
	int   chk_pending;
	int   err_data;
	int   err_count;
	int   err_extend;
	int   err_disable;

	// frame table from the stimulus file
	int fr_en [$];
	int fr_lines [$];
	int fr_len [$];
	int fr_hb [$];
	int fr_vb [$];
	int fr_rnd [$];

	int   seed;
	int   limit;
	int   cycles;
	int   end_errs;
	logic reported;

	// ----------------------------------------------------------------------
	// clocks at one rate with the sensor phase shifted
	// ----------------------------------------------------------------------

	initial begin
		clk_pix = 1'b0;
		forever #20 clk_pix = ~clk_pix;
	end

	initial begin
		clk_sensor_pix = 1'b0;
		#13;
		forever #20 clk_sensor_pix = ~clk_sensor_pix;
	end

	sensor_sync_buffer dut (
		.clk_sensor_pix (clk_sensor_pix),
		.i_clk_en       (clk_en),
		.i_fval         (fval),
		.i_lval         (lval),
		.i_pix_data     (pix_data),
		.clk_pix        (clk_pix),
		.i_reset        (reset),
		.i_enable       (enable),
		.o_fval         (out_fval),
		.o_lval         (out_lval),
		.o_pix_data     (out_pix_data)
	);

	sync_buffer_checker u_checker (
		.clk_sensor_pix   (clk_sensor_pix),
		.clk_pix          (clk_pix),
		.i_reset          (reset),
		.i_enable         (enable),
		.i_fval           (fval),
		.i_lval           (lval),
		.i_pix_data       (pix_data),
		.i_dut_fval       (out_fval),
		.i_dut_lval       (out_lval),
		.i_dut_pix_data   (out_pix_data),
		.o_idle           (chk_idle),
		.o_pending_frames (chk_pending),
		.o_err_data       (err_data),
		.o_err_count      (err_count),
		.o_err_extend     (err_extend),
		.o_err_disable    (err_disable)
	);

	bind sensor_sync_buffer sync_buffer_assert u_assert (
		.clk_pix        (clk_pix),
		.clk_sensor_pix (clk_sensor_pix),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_clk_en       (i_clk_en),
		.i_fval_out     (o_fval),
		.i_lval_out     (o_lval),
		.i_pix_out      (o_pix_data),
		.i_fifo_full    (fifo_full),
		.i_state        (u_ctrl.state)
	);

	// ----------------------------------------------------------------------
	// sensor frame generator
	// ----------------------------------------------------------------------

	function automatic logic [DATA_WIDTH-1:0] random_pixels();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[DATA_WIDTH-1:0];
	endfunction

	// one sensor clock worth of inputs
	task automatic drive_beat(input logic f, input logic l, input logic [DATA_WIDTH-1:0] d,
		input logic ce);
		@(negedge clk_sensor_pix);
		fval <= f;
		lval <= l;
		pix_data <= d;
		clk_en <= ce;
	endtask

	task automatic run_frame(input int idx);
		int   ce;
		logic glitch;
		// back on after a disabled frame
		if (!enable) begin
			@(negedge clk_pix);
			enable <= 1'b1;
		end
		// vertical blank with lval glitches and junk data
		for (int v = 0; v < fr_vb[idx]; v++) begin
			ce = 1;
			if (fr_rnd[idx] != 0 && v >= 4 && v < fr_vb[idx] - 4) begin
				ce = $random(seed) & 1;
			end
			glitch = (($random(seed) & 7) == 0);
			drive_beat(1'b0, glitch, random_pixels(), ce[0]);
		end
		// lead in before the first line
		for (int h = 0; h < fr_hb[idx]; h++) begin
			drive_beat(1'b1, 1'b0, '0, 1'b1);
		end
		for (int l = 0; l < fr_lines[idx]; l++) begin
			// cut the frame halfway
			if (fr_en[idx] == 0 && l == fr_lines[idx] / 2) begin
				@(negedge clk_pix);
				enable <= 1'b0;
			end
			for (int p = 0; p < fr_len[idx]; p++) begin
				drive_beat(1'b1, 1'b1, random_pixels(), 1'b1);
			end
			for (int h = 0; h < fr_hb[idx]; h++) begin
				drive_beat(1'b1, 1'b0, '0, 1'b1);
			end
		end
	endtask

	// returns 0 when the file is missing
	task automatic load_stimulus(output logic ok);
		int    fd;
		int    n;
		string line;
		int    en;
		int    ln;
		int    len;
		int    hb;
		int    vb;
		int    rnd;
		ok = 1'b0;
		fd = $fopen("sync_buffer_stimulus.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%d %d %d %d %d %d", en, ln, len, hb, vb, rnd) == 6) begin
						fr_en.push_back(en);
						fr_lines.push_back(ln);
						fr_len.push_back(len);
						fr_hb.push_back(hb);
						fr_vb.push_back(vb);
						fr_rnd.push_back(rnd);
						limit += ln * (len + hb) + hb + vb;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------------------------------------
	// run limit
	// ----------------------------------------------------------------------

	always @(posedge clk_pix) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d clk_pix cycles, the frames never drained", cycles);
			reported = 1'b1;
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		logic ok;
		int   total;
		seed = 32'h3441;
		reset = 1'b1;
		enable = 1'b1;
		clk_en = 1'b1;
		fval = 1'b0;
		lval = 1'b0;
		pix_data = '0;
		limit = 0;
		cycles = 0;
		end_errs = 0;
		reported = 1'b0;
		load_stimulus(ok);
		if (!ok) begin
			$display("could not open sync_buffer_stimulus.txt");
			reported = 1'b1;
			$display("Simulation failed");
			$finish;
		end else begin
			// reset cycles plus drain margin
			limit += 10 + 200;
			repeat (10) @(negedge clk_pix);
			reset <= 1'b0;
			for (int i = 0; i < fr_en.size(); i++) begin
				run_frame(i);
			end
			drive_beat(1'b0, 1'b0, '0, 1'b1);
			wait (chk_idle);
			repeat (8) @(posedge clk_pix);
			if (chk_pending != 0) begin
				end_errs++;
				$display("%0d sensor frames never showed up at the output", chk_pending);
			end
			total = err_data + err_count + err_extend + err_disable + end_errs;
			$display("errors: data_order %0d, line_count %0d, fval_extend %0d, disable %0d, end %0d",
				err_data, err_count, err_extend, err_disable, end_errs);
			reported = 1'b1;
			if (total == 0) begin
				$display("Simulation passed");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

	// run stopped by a failed assertion
	final begin
		if (!reported) begin
			$display("Simulation failed");
		end
	end

endmodule

//--- sync_buffer_checker.sv
module sync_buffer_checker (
	input  logic                              clk_sensor_pix,
	input  logic                              clk_pix,
	input  logic                              i_reset,
	input  logic                              i_enable,
	input  logic                              i_fval,
	input  logic                              i_lval,
	input  logic [sensor_pkg::DATA_WIDTH-1:0] i_pix_data,
	input  logic                              i_dut_fval,
	input  logic                              i_dut_lval,
	input  logic [sensor_pkg::DATA_WIDTH-1:0] i_dut_pix_data,
	output logic                              o_idle,
	output int                                o_pending_frames,
	output int                                o_err_data,
	output int                                o_err_count,
	output int                                o_err_extend,
	output int                                o_err_disable
);
	import sensor_pkg::*;

	// expected beats in sensor order, expected beats per frame
	sensor_beat_t beat_q [$];
	int           frame_q [$];

	// sensor side frame tracking
	logic in_fval_d;
	logic in_valid;
	int   in_cnt;
	int   err_gap;

	// output side frame tracking
	logic out_fval_d;
	logic out_valid;
	logic out_seen;
	int   out_cnt;
	int   tail_cnt;
	int   off_cnt;
	int   err_tail;

	assign o_err_extend = err_gap + err_tail;

	// ----------------------------------------------------------------------
	// sensor side, collect beats inside fval
	// ----------------------------------------------------------------------

	always @(posedge clk_sensor_pix) begin
		if (i_reset) begin
			in_fval_d = 1'b0;
			in_valid = 1'b0;
			in_cnt = 0;
			err_gap = 0;
		end else begin
			if (i_fval && !in_fval_d) begin
				in_cnt = 0;
				in_valid = i_enable;
				// previous stretched frame must be over by now
				if (i_dut_fval) begin
					err_gap++;
					$display("o_fval was still high when the next sensor frame started");
				end
			end
			// a frame cut by disable is not counted
			if (!i_enable) begin
				in_valid = 1'b0;
			end
			// lval outside fval is a glitch, never expected at the output
			if (i_fval && i_lval && i_enable) begin
				beat_q.push_back('{lval: 1'b1, data: i_pix_data});
				in_cnt++;
			end
			if (!i_fval && in_fval_d && in_valid) begin
				frame_q.push_back(in_cnt);
			end
			in_fval_d = i_fval;
		end
	end

	// ----------------------------------------------------------------------
	// output side, compare beats and frame shape
	// ----------------------------------------------------------------------

	always @(posedge clk_pix) begin
		sensor_beat_t exp_beat;
		if (i_reset) begin
			out_fval_d = 1'b0;
			out_valid = 1'b0;
			out_seen = 1'b0;
			out_cnt = 0;
			tail_cnt = 0;
			off_cnt = 0;
			err_tail = 0;
			o_err_data = 0;
			o_err_count = 0;
			o_err_disable = 0;
			o_idle = 1'b1;
			o_pending_frames = 0;
		end else if (!i_enable) begin
			// disabled, everything in flight is gone
			beat_q.delete();
			frame_q.delete();
			out_valid = 1'b0;
			if (off_cnt >= 4 && (i_dut_fval || i_dut_lval || i_dut_pix_data != '0)) begin
				o_err_disable++;
				$display("ERROR disable: expected %h actual %h", {2'b00, {DATA_WIDTH{1'b0}}},
					{i_dut_fval, i_dut_lval, i_dut_pix_data});
			end
			if (off_cnt < 1000) begin
				off_cnt++;
			end
			out_fval_d = i_dut_fval;
		end else begin
			off_cnt = 0;
			if (i_dut_fval && !out_fval_d) begin
				out_cnt = 0;
				out_valid = 1'b1;
				out_seen = 1'b0;
				tail_cnt = 0;
			end
			if (i_dut_lval) begin
				if (beat_q.size() == 0) begin
					o_err_data++;
					$display("o_lval beat seen with no sensor beat waiting for it");
				end else begin
					exp_beat = beat_q.pop_front();
					if (exp_beat.data !== i_dut_pix_data) begin
						o_err_data++;
						$display("ERROR data_order: expected %h actual %h", exp_beat.data,
							i_dut_pix_data);
					end
				end
				out_cnt++;
				out_seen = 1'b1;
				tail_cnt = 0;
			end else if (i_dut_fval) begin
				// stretch still wrapping the last line
				tail_cnt++;
			end
			if (!i_dut_fval && out_fval_d && out_valid) begin
				if (frame_q.size() == 0) begin
					o_err_count++;
					$display("output frame ended with no sensor frame behind it");
				end else if (frame_q[0] != out_cnt) begin
					o_err_count++;
					$display("ERROR line_count: expected %0d actual %0d", frame_q[0], out_cnt);
					void'(frame_q.pop_front());
				end else begin
					void'(frame_q.pop_front());
				end
				if (out_seen && tail_cnt < FVAL_EXTEND) begin
					err_tail++;
					$display("ERROR fval_extend: expected %0d actual %0d", FVAL_EXTEND, tail_cnt);
				end
				out_valid = 1'b0;
			end
			out_fval_d = i_dut_fval;
		end
		o_idle = (beat_q.size() == 0) && !i_dut_fval;
		o_pending_frames = frame_q.size();
	end

endmodule

//--- sync_buffer_assert.sv
module sync_buffer_assert (
	input  logic                              clk_pix,
	input  logic                              clk_sensor_pix,
	input  logic                              i_reset,
	input  logic                              i_enable,
	input  logic                              i_clk_en,
	input  logic                              i_fval_out,
	input  logic                              i_lval_out,
	input  logic [sensor_pkg::DATA_WIDTH-1:0] i_pix_out,
	input  logic                              i_fifo_full,
	input  sensor_pkg::frame_state_t          i_state
);
	import sensor_pkg::*;

	// ----------------------------------------------------------------------
	// output shape
	// ----------------------------------------------------------------------

	// a line only inside the stretched frame
	a_lval_in_fval: assert property (@(posedge clk_pix) disable iff (i_reset)
		i_lval_out |-> i_fval_out)
		else $error("o_lval high while o_fval low");

	// blanking carries zero pixels
	a_data_zero: assert property (@(posedge clk_pix) disable iff (i_reset)
		!i_fval_out |-> (i_pix_out == '0))
		else $error("o_pix_data nonzero while o_fval low");

	// ----------------------------------------------------------------------
	// write side and control
	// ----------------------------------------------------------------------

	// FIFO never fills in a normal stream
	a_no_full: assert property (@(posedge clk_sensor_pix) disable iff (i_reset)
		i_clk_en |-> !i_fifo_full)
		else $error("FIFO full with the sensor clock enable high");

	// disable parks the frame FSM
	a_off_when_disabled: assert property (@(posedge clk_pix) disable iff (i_reset)
		!i_enable |=> (i_state == F_OFF))
		else $error("FSM not in F_OFF after disable");

endmodule

//--- sensor_sync_buffer.sv
module sensor_sync_buffer (
	input  logic                            clk_sensor_pix,
	input  logic                            i_clk_en,
	input  logic                            i_fval,
	input  logic                            i_lval,
	input  logic [sensor_pkg::DATA_WIDTH-1:0] i_pix_data,
	input  logic                            clk_pix,
	input  logic                            i_reset,
	input  logic                            i_enable,
	output logic                            o_fval,
	output logic                            o_lval,
	output logic [sensor_pkg::DATA_WIDTH-1:0] o_pix_data
);
	import sensor_pkg::*;

	// sensor domain
	sensor_beat_t wr_beat;
	logic         fifo_wr_en;
	logic         fifo_full;

	// clk_pix domain
	sensor_beat_t rd_beat;
	logic         level_ok;
	logic         fifo_clear;
	logic         rd_en;
	logic         ext_start;
	logic         ext_running;

	// no back-pressure to the sensor, a full FIFO drops the beat
	assign fifo_wr_en = i_clk_en & ~fifo_full;

	// ----------------------------------------------------------------------
	// clock crossing
	// ----------------------------------------------------------------------

	sensor_fifo u_fifo (
		.i_wclk     (clk_sensor_pix),
		.i_wreset   (fifo_clear),
		.i_wr_en    (fifo_wr_en),
		.i_din      (wr_beat),
		.clk_pix    (clk_pix),
		.i_reset    (fifo_clear),
		.i_rd_en    (rd_en),
		.o_full     (fifo_full),
		.o_level_ok (level_ok),
		.o_dout     (rd_beat)
	);

	// ----------------------------------------------------------------------
	// frame control and stretch
	// ----------------------------------------------------------------------

	sync_ctrl_fsm u_ctrl (
		.clk_pix       (clk_pix),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_fval_async  (i_fval),
		.i_level_ok    (level_ok),
		.i_ext_running (ext_running),
		.o_ext_start   (ext_start),
		.o_fval        (o_fval),
		.o_rd_en       (rd_en),
		.o_fifo_clear  (fifo_clear)
	);

	// clear follows the FIFO clear level, i.e. disable
	fval_extend_timer u_timer (
		.clk_pix   (clk_pix),
		.i_reset   (i_reset),
		.i_clear   (fifo_clear),
		.i_start   (ext_start),
		.o_running (ext_running)
	);

	// ----------------------------------------------------------------------
	// input masking and output register
	// ----------------------------------------------------------------------

	pix_out_stage u_stage (
		.clk_sensor_pix (clk_sensor_pix),
		.i_fval         (i_fval),
		.i_lval         (i_lval),
		.i_pix_data     (i_pix_data),
		.clk_pix        (clk_pix),
		.i_reset        (i_reset),
		.i_fval_out     (o_fval),
		.i_rd_en        (rd_en),
		.i_rd_beat      (rd_beat),
		.o_wr_beat      (wr_beat),
		.o_lval         (o_lval),
		.o_pix_data     (o_pix_data)
	);

endmodule

//--- pix_out_stage.sv
module pix_out_stage (
	input  logic                            clk_sensor_pix,
	input  logic                            i_fval,
	input  logic                            i_lval,
	input  logic [sensor_pkg::DATA_WIDTH-1:0] i_pix_data,
	input  logic                            clk_pix,
	input  logic                            i_reset,
	input  logic                            i_fval_out,
	input  logic                            i_rd_en,
	input  sensor_pkg::sensor_beat_t        i_rd_beat,
	output sensor_pkg::sensor_beat_t        o_wr_beat,
	output logic                            o_lval,
	output logic [sensor_pkg::DATA_WIDTH-1:0] o_pix_data
);

	// ----------------------------------------------------------------------
	// write half, sensor clock
	// ----------------------------------------------------------------------

	// capture flop at the sensor pins
	// lval glitches in blanking die here, outside fval
	always_ff @(posedge clk_sensor_pix) begin
		o_wr_beat.lval <= i_fval & i_lval;
		o_wr_beat.data <= i_fval ? i_pix_data : '0;
	end

	// ----------------------------------------------------------------------
	// read half, clk_pix
	// ----------------------------------------------------------------------

	// pass the FIFO word only inside the stretched fval with reads running
	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			o_lval <= 1'b0;
			o_pix_data <= '0;
		end else if (i_fval_out && i_rd_en) begin
			o_lval <= i_rd_beat.lval;
			o_pix_data <= i_rd_beat.data;
		end else begin
			o_lval <= 1'b0;
			o_pix_data <= '0;
		end
	end

endmodule

//--- sync_ctrl_fsm.sv
module sync_ctrl_fsm (
	input  logic clk_pix,
	input  logic i_reset,
	input  logic i_enable,
	input  logic i_fval_async,
	input  logic i_level_ok,
	input  logic i_ext_running,
	output logic o_ext_start,
	output logic o_fval,
	output logic o_rd_en,
	output logic o_fifo_clear
);
	import sensor_pkg::*;

	logic [1:0]   fval_sync;
	logic         fval_last;
	logic         fval_rise;
	logic         fval_fall;
	frame_state_t state;
	frame_state_t next_state;

	// ----------------------------------------------------------------------
	// frame-valid sync and edge detect
	// ----------------------------------------------------------------------

	// sensor fval is async here
	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			fval_sync <= '0;
			fval_last <= 1'b0;
		end else begin
			fval_sync <= {fval_sync[0], i_fval_async};
			fval_last <= fval_sync[1];
		end
	end

	assign fval_rise = fval_sync[1] && !fval_last;
	assign fval_fall = !fval_sync[1] && fval_last;

	// ----------------------------------------------------------------------
	// frame state
	// ----------------------------------------------------------------------

	always_comb begin
		next_state = state;
		o_ext_start = 1'b0;
		case (state)
			F_OFF: begin
				next_state = F_IDLE;
			end
			F_IDLE: begin
				if (fval_rise) begin
					next_state = F_ACTIVE;
				end
			end
			F_ACTIVE: begin
				// timer loads on the same edge as the move
				if (fval_fall) begin
					next_state = F_EXTEND;
					o_ext_start = 1'b1;
				end
			end
			F_EXTEND: begin
				// back-to-back frame keeps fval high
				if (fval_rise) begin
					next_state = F_ACTIVE;
				end else if (!i_ext_running) begin
					next_state = F_IDLE;
				end
			end
			default: begin
				next_state = F_OFF;
			end
		endcase
	end

	// o_fval trails state by one edge
	// fall lands FVAL_EXTEND edges after the timer load
	// read flag is sticky until disable
	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			state <= F_OFF;
			o_fval <= 1'b0;
			o_rd_en <= 1'b0;
			o_fifo_clear <= 1'b1;
		end else begin
			o_fval <= (state == F_ACTIVE) || (state == F_EXTEND && i_ext_running);
			if (!i_enable) begin
				state <= F_OFF;
				o_rd_en <= 1'b0;
				o_fifo_clear <= 1'b1;
			end else begin
				state <= next_state;
				o_fifo_clear <= 1'b0;
				if (i_level_ok) begin
					o_rd_en <= 1'b1;
				end
			end
		end
	end

endmodule

//--- fval_extend_timer.sv
module fval_extend_timer (
	input  logic clk_pix,
	input  logic i_reset,
	input  logic i_clear,
	input  logic i_start,
	output logic o_running
);
	import sensor_pkg::*;

	logic [EXT_WIDTH-1:0] ext_cnt;

	// ----------------------------------------------------------------------
	// stretch counter
	// ----------------------------------------------------------------------

	// parked at the top value while idle
	// start loads zero, count up and stop at the top
	always_ff @(posedge clk_pix) begin
		if (i_reset || i_clear) begin
			ext_cnt <= EXT_WIDTH'(FVAL_EXTEND - 1);
		end else if (i_start) begin
			ext_cnt <= '0;
		end else if (ext_cnt != EXT_WIDTH'(FVAL_EXTEND - 1)) begin
			ext_cnt <= ext_cnt + 1'b1;
		end
	end

	// high for FVAL_EXTEND - 1 cycles after the load
	assign o_running = (ext_cnt < EXT_WIDTH'(FVAL_EXTEND - 1));

endmodule

//--- sensor_fifo.sv
module sensor_fifo (
	input  logic                     i_wclk,
	input  logic                     i_wreset,
	input  logic                     i_wr_en,
	input  sensor_pkg::sensor_beat_t i_din,
	input  logic                     clk_pix,
	input  logic                     i_reset,
	input  logic                     i_rd_en,
	output logic                     o_full,
	output logic                     o_level_ok,
	output sensor_pkg::sensor_beat_t o_dout
);
	import sensor_pkg::*;

	// beat storage with a registered read port
	sensor_beat_t mem [FIFO_DEPTH];

	// write side
	logic [1:0]       wclr_sync;
	logic             wclr;
	logic [FIFO_AW:0] wbin;
	logic [FIFO_AW:0] wbin_next;
	logic [FIFO_AW:0] wgray;
	logic [FIFO_AW:0] rgray_w1;
	logic [FIFO_AW:0] rgray_w2;

	// read side
	logic [FIFO_AW:0] rbin;
	logic [FIFO_AW:0] rbin_next;
	logic [FIFO_AW:0] rgray;
	logic [FIFO_AW:0] wgray_r1;
	logic [FIFO_AW:0] wgray_r2;
	logic [FIFO_AW:0] rd_level;
	logic             rd_empty;
	logic             rd_fire;

	function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] gray);
		logic [FIFO_AW:0] bin;
		bin[FIFO_AW] = gray[FIFO_AW];
		for (int i = FIFO_AW - 1; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

	// ----------------------------------------------------------------------
	// write domain on i_wclk
	// ----------------------------------------------------------------------

	// clear level from clk_pix through two flops
	always_ff @(posedge i_wclk) begin
		wclr_sync <= {wclr_sync[0], i_wreset};
	end
	assign wclr = wclr_sync[1];

	// caller keeps i_wr_en low while full
	assign wbin_next = wbin + 1'b1;

	always_ff @(posedge i_wclk) begin
		if (wclr) begin
			wbin <= '0;
			wgray <= '0;
		end else if (i_wr_en) begin
			wbin <= wbin_next;
			wgray <= wbin_next ^ (wbin_next >> 1);
		end
	end

	always_ff @(posedge i_wclk) begin
		if (i_wr_en && !wclr) begin
			mem[wbin[FIFO_AW-1:0]] <= i_din;
		end
	end

	// read pointer into the write side
	always_ff @(posedge i_wclk) begin
		if (wclr) begin
			rgray_w1 <= '0;
			rgray_w2 <= '0;
		end else begin
			rgray_w1 <= rgray;
			rgray_w2 <= rgray_w1;
		end
	end

	// full when the gray pointers differ only in the two msbs
	assign o_full = (wgray == {~rgray_w2[FIFO_AW:FIFO_AW-1], rgray_w2[FIFO_AW-2:0]});

	// ----------------------------------------------------------------------
	// read domain on clk_pix
	// ----------------------------------------------------------------------

	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			wgray_r1 <= '0;
			wgray_r2 <= '0;
		end else begin
			wgray_r1 <= wgray;
			wgray_r2 <= wgray_r1;
		end
	end

	assign rd_empty = (rgray == wgray_r2);
	// an empty read leaves pointer and word alone
	assign rd_fire = i_rd_en && !rd_empty;
	assign rbin_next = rbin + 1'b1;

	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			rbin <= '0;
			rgray <= '0;
		end else if (rd_fire) begin
			rbin <= rbin_next;
			rgray <= rbin_next ^ (rbin_next >> 1);
		end
	end

	// occupancy seen from clk_pix lags the writer by the sync
	assign rd_level = gray2bin(wgray_r2) - rbin;

	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			o_level_ok <= 1'b0;
		end else begin
			o_level_ok <= (rd_level >= (FIFO_AW + 1)'(FILL_LEVEL));
		end
	end

	// read word register with lval cleared along with the FIFO
	always_ff @(posedge clk_pix) begin
		if (i_reset) begin
			o_dout.lval <= 1'b0;
		end else if (rd_fire) begin
			o_dout <= mem[rbin[FIFO_AW-1:0]];
		end
	end

endmodule

//--- sensor_pkg.sv
package sensor_pkg;

	// ----------------------------------------------------------------------
	// pixel bus
	// ----------------------------------------------------------------------

	// bits per channel
	localparam int PIX_WIDTH = 10;
	// channels side by side on the bus
	localparam int CHANNEL_NUM = 4;
	localparam int DATA_WIDTH = PIX_WIDTH * CHANNEL_NUM;

	// ----------------------------------------------------------------------
	// crossing FIFO
	// ----------------------------------------------------------------------

	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_AW = 5;
	// words held before the read side starts
	localparam int FILL_LEVEL = 10;

	// ----------------------------------------------------------------------
	// frame-valid stretch
	// ----------------------------------------------------------------------

	// clk_pix cycles held past the detected fall
	localparam int FVAL_EXTEND = 20;
	localparam int EXT_WIDTH = 5;

	// one sensor beat, the FIFO word
	typedef struct packed {
		logic                  lval;
		logic [DATA_WIDTH-1:0] data;
	} sensor_beat_t;

	// frame tracking in the clk_pix domain
	typedef enum logic [1:0] {
		F_OFF    = 2'd0,
		F_IDLE   = 2'd1,
		F_ACTIVE = 2'd2,
		F_EXTEND = 2'd3
	} frame_state_t;

endpackage
